/* source/ddr_bus_pkg.sv */
package ddr_bus_pkg;

  // ==================================================
  // ddr side widths
  // ==================================================

  localparam int awidth = 32;
  localparam int lwidth = 16;

  // log2 of bytes per beat
  localparam int lsb = 3;

  // beat address on the ddr bus
  typedef logic [awidth-1:0] beat_addr_t;

  // byte address, beat address shifted by lsb
  typedef logic [awidth+lsb-1:0] byte_addr_t;

  // length in words or beats
  typedef logic [lwidth-1:0] len_t;

  // ==================================================
  // request modes
  // ==================================================

  localparam logic ddr_read  = 1'b0;
  localparam logic ddr_write = 1'b1;

endpackage

/* source/buf_word_pkg.sv */
package buf_word_pkg;

  // ==================================================
  // core word and beat geometry
  // ==================================================

  localparam int dwidth  = 16;
  localparam int rate    = 4;
  localparam int ratelog = 2;
  localparam int bwidth  = dwidth * rate;
  localparam int awidth  = 16;

  // signed core word
  typedef logic signed [dwidth-1:0] word_t;

  // word address on the core side
  typedef logic [awidth-1:0] word_addr_t;

  // ==================================================
  // beat views
  // ==================================================

  // raw for the ddr side and the buffers, lane for the core side
  // lane 0 is the lowest word address
  typedef union packed {
    logic [bwidth-1:0]  raw;
    word_t [rate-1:0]   lane;
  } beat_t;

endpackage

/* source/buf_ram.sv */
`timescale 1ns/10ps

module buf_ram #(
  parameter int buf_log = 4
) (
  input  logic                clk,
  input  logic                we,
  input  logic [buf_log-1:0]  addr,
  input  buf_word_pkg::beat_t wdata,
  output buf_word_pkg::beat_t rdata
);

  localparam int depth = 2 ** buf_log;

  buf_word_pkg::beat_t mem [0:depth-1];

  // single port, read data registered
  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    rdata <= mem[addr];
  end

endmodule

/* source/prefetch_unit.sv */
`timescale 1ns/10ps

module prefetch_unit #(
  parameter int buf_log   = 4,
  parameter int burst_max = 16
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     pre_req,
  input  ddr_bus_pkg::beat_addr_t  pre_base,
  input  ddr_bus_pkg::len_t        read_len,
  input  logic                     ddr_we,
  input  ddr_bus_pkg::beat_addr_t  ddr_waddr,
  input  buf_word_pkg::beat_t      ddr_wdata,
  input  logic                     mem_we,
  input  buf_word_pkg::word_addr_t mem_addr,
  output logic                     pre_ack,
  output logic                     rd_start,
  output ddr_bus_pkg::byte_addr_t  rd_base,
  output ddr_bus_pkg::len_t        rd_beats,
  output buf_word_pkg::word_t      mem_rdata
);

  localparam logic s_idle = 1'b0;
  localparam logic s_fill = 1'b1;

  logic                             state;
  logic                             pre_req_d;
  logic                             start;
  logic                             fill_end;
  ddr_bus_pkg::beat_addr_t          base_q;
  ddr_bus_pkg::len_t                beats_q;
  ddr_bus_pkg::len_t                beats_in;
  ddr_bus_pkg::len_t                count;
  ddr_bus_pkg::beat_addr_t          word_beat;
  ddr_bus_pkg::beat_addr_t          offset;
  logic                             ram_we;
  logic [buf_log-1:0]               ram_addr;
  buf_word_pkg::beat_t              ram_rdata;
  logic [buf_word_pkg::ratelog-1:0] lane_q;

  // ==================================================
  // command and fill control
  // ==================================================

  // zero length read leaves the prefetcher idle
  assign start    = pre_req && !pre_req_d && state == s_idle && read_len != '0;
  assign fill_end = state == s_fill && ddr_we && count == beats_q - 1'b1;
  assign pre_ack  = state == s_idle;

  // words rounded up to beats and capped at one burst
  always_comb begin
    beats_in = (read_len >> buf_word_pkg::ratelog)
             + ddr_bus_pkg::len_t'(|read_len[buf_word_pkg::ratelog-1:0]);
    if (beats_in > ddr_bus_pkg::len_t'(burst_max))
      beats_in = ddr_bus_pkg::len_t'(burst_max);
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= s_idle;
      pre_req_d <= 1'b0;
      rd_start  <= 1'b0;
      count     <= '0;
    end else begin
      pre_req_d <= pre_req;
      rd_start  <= start;
      case (state)
        s_idle:
          if (start) begin
            state <= s_fill;
            count <= '0;
          end
        s_fill:
          if (fill_end)
            state <= s_idle;
          else if (ddr_we)
            count <= count + 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      base_q  <= pre_base;
      beats_q <= beats_in;
    end
  end

  assign rd_base  = ddr_bus_pkg::byte_addr_t'(base_q) << ddr_bus_pkg::lsb;
  assign rd_beats = beats_q;

  // ==================================================
  // prefetch buffer
  // ==================================================

  assign word_beat = ddr_bus_pkg::beat_addr_t'(mem_addr >> buf_word_pkg::ratelog);
  assign offset    = (state == s_fill) ? ddr_waddr - base_q : word_beat - base_q;
  assign ram_addr  = offset[buf_log-1:0];
  assign ram_we    = state == s_fill && ddr_we;

  buf_ram #(
    .buf_log (buf_log)
  ) pre_ram (
    .clk   (clk),
    .we    (ram_we),
    .addr  (ram_addr),
    .wdata (ddr_wdata),
    .rdata (ram_rdata)
  );

  // lane follows the read address by one cycle
  always_ff @(posedge clk) begin
    if (!xrst)
      lane_q <= '0;
    else if (!mem_we)
      lane_q <= mem_addr[buf_word_pkg::ratelog-1:0];
  end

  assign mem_rdata = ram_rdata.lane[lane_q];

endmodule

/* source/post_unit.sv */
`timescale 1ns/10ps

module post_unit #(
  parameter int buf_log   = 4,
  parameter int burst_max = 16
) (
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     pre_req,
  input  ddr_bus_pkg::len_t        write_len,
  input  logic                     mem_we,
  input  buf_word_pkg::word_addr_t mem_addr,
  input  buf_word_pkg::word_t      mem_wdata,
  input  ddr_bus_pkg::beat_addr_t  ddr_raddr,
  output logic                     wr_start,
  output ddr_bus_pkg::byte_addr_t  wr_base,
  output ddr_bus_pkg::len_t        wr_beats,
  output buf_word_pkg::beat_t      ddr_rdata
);

  logic                             pre_req_d;
  logic                             pre_edge;
  logic                             active;
  logic                             first;
  logic                             take;
  logic                             last_word;
  logic                             beat_done;
  ddr_bus_pkg::len_t                len_q;
  ddr_bus_pkg::len_t                beats_q;
  ddr_bus_pkg::len_t                beats_in;
  ddr_bus_pkg::len_t                word_cnt;
  ddr_bus_pkg::beat_addr_t          base_q;
  ddr_bus_pkg::beat_addr_t          base_now;
  ddr_bus_pkg::beat_addr_t          word_beat;
  ddr_bus_pkg::beat_addr_t          offset;
  ddr_bus_pkg::beat_addr_t          drain_off;
  logic [buf_word_pkg::ratelog-1:0] lane;
  buf_word_pkg::beat_t              pack_q;
  buf_word_pkg::beat_t              pack_next;
  logic                             ram_we_q;
  logic [buf_log-1:0]               ram_waddr_q;
  logic [buf_log-1:0]               ram_addr;

  // ==================================================
  // word sequence
  // ==================================================

  assign pre_edge  = pre_req && !pre_req_d;
  assign take      = active && mem_we && !pre_edge;
  assign last_word = word_cnt == len_q - 1'b1;
  assign lane      = mem_addr[buf_word_pkg::ratelog-1:0];
  assign beat_done = lane == buf_word_pkg::ratelog'(buf_word_pkg::rate - 1) || last_word;

  always_comb begin
    beats_in = (write_len >> buf_word_pkg::ratelog)
             + ddr_bus_pkg::len_t'(|write_len[buf_word_pkg::ratelog-1:0]);
    if (beats_in > ddr_bus_pkg::len_t'(burst_max))
      beats_in = ddr_bus_pkg::len_t'(burst_max);
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      pre_req_d <= 1'b0;
      active    <= 1'b0;
      first     <= 1'b0;
      word_cnt  <= '0;
      ram_we_q  <= 1'b0;
      wr_start  <= 1'b0;
    end else begin
      pre_req_d <= pre_req;
      ram_we_q  <= take && beat_done;
      wr_start  <= take && last_word;
      if (pre_edge) begin
        active   <= write_len != '0;
        first    <= 1'b1;
        word_cnt <= '0;
      end else if (take) begin
        first    <= 1'b0;
        word_cnt <= word_cnt + 1'b1;
        if (last_word)
          active <= 1'b0;
      end
    end
  end

  // ==================================================
  // packing
  // ==================================================

  // first write of a sequence fixes the post base
  assign word_beat = ddr_bus_pkg::beat_addr_t'(mem_addr >> buf_word_pkg::ratelog);
  assign base_now  = first ? word_beat : base_q;
  assign offset    = word_beat - base_now;

  // lane 0 starts a fresh beat, unwritten lanes stay zero
  always_comb begin
    pack_next = pack_q;
    if (lane == '0)
      pack_next.raw = '0;
    pack_next.lane[lane] = mem_wdata;
  end

  always_ff @(posedge clk) begin
    if (pre_edge) begin
      len_q   <= write_len;
      beats_q <= beats_in;
    end
    if (take) begin
      base_q      <= base_now;
      pack_q      <= pack_next;
      ram_waddr_q <= offset[buf_log-1:0];
    end
  end

  assign wr_base  = ddr_bus_pkg::byte_addr_t'(base_q) << ddr_bus_pkg::lsb;
  assign wr_beats = beats_q;

  // ==================================================
  // post buffer
  // ==================================================

  // drain reads relative to the post base
  assign drain_off = ddr_raddr - base_q;
  assign ram_addr  = ram_we_q ? ram_waddr_q : drain_off[buf_log-1:0];

  buf_ram #(
    .buf_log (buf_log)
  ) post_ram (
    .clk   (clk),
    .we    (ram_we_q),
    .addr  (ram_addr),
    .wdata (pack_q),
    .rdata (ddr_rdata)
  );

endmodule

/* source/ddr_port.sv */
`timescale 1ns/10ps

module ddr_port (
  input  logic                    clk,
  input  logic                    xrst,
  input  logic                    rd_start,
  input  ddr_bus_pkg::byte_addr_t rd_base,
  input  ddr_bus_pkg::len_t       rd_beats,
  input  logic                    wr_start,
  input  ddr_bus_pkg::byte_addr_t wr_base,
  input  ddr_bus_pkg::len_t       wr_beats,
  output logic                    ddr_req,
  output logic                    ddr_mode,
  output ddr_bus_pkg::byte_addr_t ddr_base,
  output ddr_bus_pkg::len_t       ddr_len
);

  logic rd_pend;
  logic wr_pend;
  logic rd_want;
  logic wr_want;
  logic issue_rd;
  logic issue_wr;

  // base and length stay held by the units, so a flag is enough to wait
  assign rd_want = rd_start || rd_pend;
  assign wr_want = wr_start || wr_pend;

  // reads first, and never two strobes back to back
  assign issue_rd = !ddr_req && rd_want;
  assign issue_wr = !ddr_req && !rd_want && wr_want;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      ddr_req <= 1'b0;
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
    end else begin
      ddr_req <= issue_rd || issue_wr;
      rd_pend <= rd_want && !issue_rd;
      wr_pend <= wr_want && !issue_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_rd) begin
      ddr_mode <= ddr_bus_pkg::ddr_read;
      ddr_base <= rd_base;
      ddr_len  <= rd_beats;
    end else if (issue_wr) begin
      ddr_mode <= ddr_bus_pkg::ddr_write;
      ddr_base <= wr_base;
      ddr_len  <= wr_beats;
    end
  end

endmodule

/* source/ninjin_ddr_buf.sv */
`timescale 1ns/10ps

module ninjin_ddr_buf #(
  parameter int buf_log   = 4,
  parameter int burst_max = 16
) (
  input  logic                     clk,
  input  logic                     xrst,
  // core side
  input  logic                     pre_req,
  input  ddr_bus_pkg::beat_addr_t  pre_base,
  input  ddr_bus_pkg::len_t        read_len,
  input  ddr_bus_pkg::len_t        write_len,
  input  logic                     mem_we,
  input  buf_word_pkg::word_addr_t mem_addr,
  input  buf_word_pkg::word_t      mem_wdata,
  output logic                     pre_ack,
  output buf_word_pkg::word_t      mem_rdata,
  // ddr side, fed back
  input  logic                     ddr_we,
  input  ddr_bus_pkg::beat_addr_t  ddr_waddr,
  input  buf_word_pkg::beat_t      ddr_wdata,
  input  ddr_bus_pkg::beat_addr_t  ddr_raddr,
  output logic                     ddr_req,
  output logic                     ddr_mode,
  output ddr_bus_pkg::byte_addr_t  ddr_base,
  output ddr_bus_pkg::len_t        ddr_len,
  output buf_word_pkg::beat_t      ddr_rdata
);

  logic                    rd_start;
  ddr_bus_pkg::byte_addr_t rd_base;
  ddr_bus_pkg::len_t       rd_beats;
  logic                    wr_start;
  ddr_bus_pkg::byte_addr_t wr_base;
  ddr_bus_pkg::len_t       wr_beats;

  prefetch_unit #(
    .buf_log   (buf_log),
    .burst_max (burst_max)
  ) prefetch_unit_i (
    .*
  );

  post_unit #(
    .buf_log   (buf_log),
    .burst_max (burst_max)
  ) post_unit_i (
    .*
  );

  ddr_port ddr_port_i (
    .*
  );

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
  parameter int period       = 20,
  parameter int reset_cycles = 5
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // reset held low over the first cycles
  initial begin
    xrst = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 xrst = 1'b1;
  end

endmodule

/* sim/ninjin_ddr_buf_assertions.sv */
`timescale 1ns/10ps

module ninjin_ddr_buf_assertions #(
  parameter int burst_max = 16
) (
  input logic              clk,
  input logic              xrst,
  input logic              pre_ack,
  input logic              ddr_req,
  input logic              ddr_mode,
  input ddr_bus_pkg::len_t ddr_len
);

  int fail_count = 0;

  // at least one idle cycle between strobes
  req_gap: assert property (@(posedge clk) disable iff (!xrst) ddr_req |=> !ddr_req)
    else begin
      fail_count++;
      $error("ddr_req was high in two consecutive cycles");
    end

  req_len: assert property (@(posedge clk) disable iff (!xrst)
    ddr_req |-> (ddr_len != '0 && ddr_len <= ddr_bus_pkg::len_t'(burst_max)))
    else begin
      fail_count++;
      $error("ddr_len out of range on a request");
    end

  // the prefetcher is busy while its read is out
  read_busy: assert property (@(posedge clk) disable iff (!xrst)
    (ddr_req && ddr_mode == ddr_bus_pkg::ddr_read) |-> !pre_ack)
    else begin
      fail_count++;
      $error("read request issued while pre_ack was high");
    end

endmodule

/* sim/ninjin_ddr_buf_tb.sv */
`timescale 1ns/10ps

module ninjin_ddr_buf_tb;

  localparam int period          = 20;
  localparam int n_tests         = 5;
  localparam int cycles_per_test = 400;
  localparam int watchdog_ns     = n_tests * cycles_per_test * period;
  localparam int wait_limit      = 100;

  logic                     clk;
  logic                     xrst;
  logic                     pre_req;
  ddr_bus_pkg::beat_addr_t  pre_base;
  ddr_bus_pkg::len_t        read_len;
  ddr_bus_pkg::len_t        write_len;
  logic                     mem_we;
  buf_word_pkg::word_addr_t mem_addr;
  buf_word_pkg::word_t      mem_wdata;
  logic                     pre_ack;
  buf_word_pkg::word_t      mem_rdata;
  logic                     ddr_we;
  ddr_bus_pkg::beat_addr_t  ddr_waddr;
  buf_word_pkg::beat_t      ddr_wdata;
  ddr_bus_pkg::beat_addr_t  ddr_raddr;
  logic                     ddr_req;
  logic                     ddr_mode;
  ddr_bus_pkg::byte_addr_t  ddr_base;
  ddr_bus_pkg::len_t        ddr_len;
  buf_word_pkg::beat_t      ddr_rdata;

  buf_word_pkg::beat_t ddr_mem [0:255];
  buf_word_pkg::word_t sent [$];
  int                  seed = 39;
  int                  drain_count = 0;

  clock_gen #(
    .period       (period),
    .reset_cycles (5)
  ) clock_gen_i (
    .clk  (clk),
    .xrst (xrst)
  );

  ninjin_ddr_buf #(
    .buf_log   (4),
    .burst_max (16)
  ) ninjin_ddr_buf_i (
    .*
  );

  bind ninjin_ddr_buf ninjin_ddr_buf_assertions #(
    .burst_max (burst_max)
  ) assertions_i (
    .clk      (clk),
    .xrst     (xrst),
    .pre_ack  (pre_ack),
    .ddr_req  (ddr_req),
    .ddr_mode (ddr_mode),
    .ddr_len  (ddr_len)
  );

  // ==================================================
  // helpers and compare tasks
  // ==================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_word(input string name, input buf_word_pkg::word_t exp,
                            input buf_word_pkg::word_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_beat(input string name, input buf_word_pkg::beat_t exp,
                            input buf_word_pkg::beat_t act);
    if (act.raw !== exp.raw) begin
      $display("FAILED %s: expected %h, actual %h", name, exp.raw, act.raw);
      abort_run();
    end
  endtask

  task automatic check_len(input string name, input ddr_bus_pkg::len_t exp,
                           input ddr_bus_pkg::len_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_addr(input string name, input ddr_bus_pkg::byte_addr_t exp,
                            input ddr_bus_pkg::byte_addr_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  // bytes per beat from the beat width
  function automatic ddr_bus_pkg::byte_addr_t byte_address(input int beat);
    return ddr_bus_pkg::byte_addr_t'(beat)
           * ddr_bus_pkg::byte_addr_t'(buf_word_pkg::bwidth / 8);
  endfunction

  // model memory word with lane 0 as the lowest word
  function automatic buf_word_pkg::word_t model_word(input int wa);
    ddr_bus_pkg::beat_addr_t ba;
    buf_word_pkg::beat_t     b;
    ba = ddr_bus_pkg::beat_addr_t'(wa / buf_word_pkg::rate);
    b  = ddr_mem[ba[7:0]];
    return buf_word_pkg::word_t'(b.raw >> ((wa % buf_word_pkg::rate) * buf_word_pkg::dwidth));
  endfunction

  function automatic buf_word_pkg::word_t sent_word(input int i);
    return (i < sent.size()) ? sent[i] : '0;
  endfunction

  task automatic load_ddr_model();
    ddr_bus_pkg::beat_addr_t ba;
    logic [31:0]             lo;
    logic [31:0]             hi;
    for (int i = 0; i < 256; i++) begin
      ba = ddr_bus_pkg::beat_addr_t'(i);
      lo = $random(seed);
      hi = $random(seed);
      ddr_mem[ba[7:0]] = {hi, lo};
    end
  endtask

  // ==================================================
  // ddr model
  // ==================================================

  initial begin : ddr_model
    ddr_bus_pkg::beat_addr_t a;
    ddr_bus_pkg::beat_addr_t addr;
    int                      n;
    ddr_we    = 1'b0;
    ddr_waddr = '0;
    ddr_wdata = '0;
    ddr_raddr = '0;
    forever begin
      next_cycle();
      if (ddr_req) begin
        a = ddr_bus_pkg::beat_addr_t'(ddr_base >> ddr_bus_pkg::lsb);
        n = int'(ddr_len);
        if (ddr_mode == ddr_bus_pkg::ddr_read) begin
          for (int k = 0; k < n; k++) begin
            addr      = a + ddr_bus_pkg::beat_addr_t'(k);
            ddr_we    = 1'b1;
            ddr_waddr = addr;
            ddr_wdata = ddr_mem[addr[7:0]];
            next_cycle();
          end
          ddr_we = 1'b0;
        end else begin
          // rdata follows raddr by one cycle
          for (int k = 0; k < n; k++) begin
            addr      = a + ddr_bus_pkg::beat_addr_t'(k);
            ddr_raddr = addr;
            next_cycle();
            ddr_mem[addr[7:0]] = ddr_rdata;
          end
          drain_count++;
        end
      end
    end
  end

  // ==================================================
  // directed tests
  // ==================================================

  task automatic check_after_reset();
    check_bit("reset pre_ack", 1'b1, pre_ack);
    check_bit("reset ddr_req", 1'b0, ddr_req);
  endtask

  task automatic prefetch_and_read(input string name, input int base, input int words);
    int waited;
    int a0;
    waited    = 0;
    a0        = base * buf_word_pkg::rate;
    pre_req   = 1'b1;
    pre_base  = ddr_bus_pkg::beat_addr_t'(base);
    read_len  = ddr_bus_pkg::len_t'(words);
    write_len = '0;
    next_cycle();
    pre_req = 1'b0;
    check_bit({name, " pre_ack after edge"}, 1'b0, pre_ack);
    next_cycle();
    check_bit({name, " ddr_req"}, 1'b1, ddr_req);
    check_bit({name, " ddr_mode"}, ddr_bus_pkg::ddr_read, ddr_mode);
    check_addr({name, " ddr_base"}, byte_address(base), ddr_base);
    check_len({name, " ddr_len"},
              ddr_bus_pkg::len_t'((words + buf_word_pkg::rate - 1) / buf_word_pkg::rate),
              ddr_len);
    while (pre_ack !== 1'b1) begin
      if (waited == wait_limit) begin
        $display("%s: pre_ack did not rise after the fill", name);
        abort_run();
      end
      waited++;
      next_cycle();
    end
    mem_we   = 1'b0;
    mem_addr = buf_word_pkg::word_addr_t'(a0);
    for (int k = 0; k < words; k++) begin
      next_cycle();
      check_word($sformatf("%s word %0d", name, a0 + k), model_word(a0 + k), mem_rdata);
      mem_addr = buf_word_pkg::word_addr_t'(a0 + k + 1);
    end
  endtask

  task automatic pack_and_drain(input string name, input int base, input int words);
    int                      waited;
    int                      drains;
    int                      beats;
    logic [31:0]             r;
    ddr_bus_pkg::beat_addr_t ba;
    buf_word_pkg::beat_t     exp;
    waited    = 0;
    drains    = drain_count;
    beats     = (words + buf_word_pkg::rate - 1) / buf_word_pkg::rate;
    sent.delete();
    pre_req   = 1'b1;
    read_len  = '0;
    write_len = ddr_bus_pkg::len_t'(words);
    next_cycle();
    pre_req = 1'b0;
    for (int k = 0; k < words; k++) begin
      r = $random(seed);
      sent.push_back(buf_word_pkg::word_t'(r[15:0]));
      mem_we    = 1'b1;
      mem_addr  = buf_word_pkg::word_addr_t'(base * buf_word_pkg::rate + k);
      mem_wdata = sent[k];
      next_cycle();
    end
    mem_we = 1'b0;
    next_cycle();
    check_bit({name, " ddr_req"}, 1'b1, ddr_req);
    check_bit({name, " ddr_mode"}, ddr_bus_pkg::ddr_write, ddr_mode);
    check_addr({name, " ddr_base"}, byte_address(base), ddr_base);
    check_len({name, " ddr_len"}, ddr_bus_pkg::len_t'(beats), ddr_len);
    while (drain_count == drains) begin
      if (waited == wait_limit) begin
        $display("%s: the DDR model never finished draining", name);
        abort_run();
      end
      waited++;
      next_cycle();
    end
    // missing words of the last beat read as zero
    for (int b = 0; b < beats; b++) begin
      ba  = ddr_bus_pkg::beat_addr_t'(base + b);
      exp = {sent_word(4 * b + 3), sent_word(4 * b + 2), sent_word(4 * b + 1),
             sent_word(4 * b)};
      check_beat($sformatf("%s beat %0d", name, b), exp, ddr_mem[ba[7:0]]);
    end
  endtask

  // ==================================================
  // run control
  // ==================================================

  always @(posedge clk) begin
    if (ninjin_ddr_buf_i.assertions_i.fail_count != 0) begin
      $display("a check on the DDR request outputs failed");
      abort_run();
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout: the run did not finish in time");
    abort_run();
  end

  initial begin : main
    pre_req   = 1'b0;
    pre_base  = '0;
    read_len  = '0;
    write_len = '0;
    mem_we    = 1'b0;
    mem_addr  = '0;
    mem_wdata = '0;
    load_ddr_model();
    wait (xrst === 1'b1);
    next_cycle();
    check_after_reset();
    prefetch_and_read("prefetch 64 words", 16, 64);
    prefetch_and_read("prefetch 10 words", 40, 10);
    pack_and_drain("write 32 words", 64, 32);
    pack_and_drain("write 6 words", 96, 6);
    if (ninjin_ddr_buf_i.assertions_i.fail_count == 0) begin
      $display("all tests passed");
      $finish;
    end else begin
      $display("checks on the DDR request outputs failed");
      abort_run();
    end
  end

endmodule

/* build.f */
source/ddr_bus_pkg.sv
source/buf_word_pkg.sv
source/buf_ram.sv
source/prefetch_unit.sv
source/post_unit.sv
source/ddr_port.sv
source/ninjin_ddr_buf.sv
sim/clock_gen.sv
sim/ninjin_ddr_buf_assertions.sv
sim/ninjin_ddr_buf_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
SIMFLAGS  = +verilator+error+limit+100
TOP       = ninjin_ddr_buf_tb
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
